// ==== build.f ====
+incdir+src
src/alloc_pkg.sv
src/rr_arbiter.sv
src/vc_allocator.sv
src/sw_alloc_stage.sv
src/spec_sw_allocator.sv
src/router_allocator.sv
dv/router_allocator_tb.sv

// ==== dv/alloc_golden.txt ====
// req vc0..vc9 (10 bit ivc_req_t each), ovc_grant {vc9..vc0}, ovc_taken,
// sw_grant port0..port4 ({ivc, dest, spec}), port_granted; all hex
// idle after reset
000 000 000 000 000 000 000 000 000 000 00000 000 00 00 00 00 00 00
// lone vc allocation, lowest free output vc
016 000 000 000 000 000 000 000 000 000 00001 010 00 00 00 00 00 00
000 000 000 044 000 000 000 000 000 000 00080 200 00 00 00 00 00 00
// port 1 and port 4 fight for output vc 6
000 000 022 000 000 000 000 000 042 000 00010 040 00 00 00 00 00 00
000 000 022 000 000 000 000 000 042 000 10000 040 00 00 00 00 00 00
000 000 022 000 000 000 000 000 042 000 00010 040 00 00 00 00 00 00
000 000 022 000 000 000 000 000 042 000 10000 040 00 00 00 00 00 00
// non-spec switch request, then the same with a full output vc
000 000 000 000 388 000 000 000 000 000 00000 000 00 00 22 00 00 04
000 000 000 000 308 000 000 000 000 000 00000 000 00 00 00 00 00 00
// speculation that wins vc allocation, then one that loses it
000 000 000 000 000 000 212 000 000 000 01000 004 00 00 00 25 00 08
00A 000 000 000 000 000 212 000 000 000 00001 004 00 00 00 00 00 00
// spec loses to non-spec on the output port, then on the input port
000 000 20A 000 388 000 000 000 000 000 00010 001 00 00 22 00 00 04
000 000 000 000 388 224 000 000 000 000 00800 080 00 00 22 00 00 04
// spec and non-spec side by side
000 000 000 000 388 000 212 000 000 000 01000 004 00 00 22 25 00 0C
// two non-spec inputs share output port 4
3C0 000 3C0 000 000 000 000 000 000 000 00000 000 30 00 00 00 00 01
3C0 000 3C0 000 000 000 000 000 000 000 00000 000 00 30 00 00 00 02
3C0 000 3C0 000 000 000 000 000 000 000 00000 000 30 00 00 00 00 01
000 000 000 000 000 000 000 000 000 000 00000 000 00 00 00 00 00 00

// ==== dv/router_allocator_tb.sv ====
`timescale 1ns/10ps
`include "alloc_config.svh"

module router_allocator_tb;

    localparam int REQ_W = $bits(alloc_pkg::ivc_req_t);
    localparam int GNT_W = $bits(alloc_pkg::port_grant_t);
    localparam int RANDOM_CYCLES = 200;
    localparam int TIMEOUT_MARGIN = 50;
    localparam int RAND_SEED = 25487;
    localparam string GOLDEN_FILE = "dv/alloc_golden.txt";

    // one directed cycle, stimulus and expected outputs
    typedef struct packed {
        logic [`ALLOC_PV*REQ_W-1:0]    req;
        logic [`ALLOC_PV*`ALLOC_V-1:0] ovc_grant;
        logic [`ALLOC_PV-1:0]          ovc_taken;
        logic [`ALLOC_P*GNT_W-1:0]     sw_grant;
        logic [`ALLOC_P-1:0]           port_granted;
    } golden_row_t;

    logic clk = 1'b0;
    logic rst_n;
    alloc_pkg::ivc_req_t    req       [`ALLOC_PV];
    alloc_pkg::vc_mask_t    ovc_grant [`ALLOC_PV];
    logic [`ALLOC_PV-1:0]   ovc_taken;
    alloc_pkg::port_grant_t sw_grant  [`ALLOC_P];
    alloc_pkg::port_mask_t  port_granted;

    golden_row_t rows [$];
    int mismatch_errors = 0;
    int invariant_errors = 0;
    int other_errors = 0;
    int cycle_count = 0;
    int cycle_limit = RANDOM_CYCLES + TIMEOUT_MARGIN;
    int seed_value;

    router_allocator router_allocator_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .ovc_grant   (ovc_grant),
        .ovc_taken   (ovc_taken),
        .sw_grant    (sw_grant),
        .port_granted(port_granted)
    );

    always #4 clk = ~clk;  // 8 ns period

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            other_errors++;
            $display("run stopped after %0d cycles without finishing", cycle_count);
            finish_run();
        end
    end

    // output port reached through dest bit k of input port in_port
    function automatic int other_port(int in_port, int k);
        return (k < in_port) ? k : k + 1;
    endfunction

    function automatic int lowest_bit(logic [7:0] m);
        for (int b = 0; b < 8; b++) begin
            if (m[b]) begin
                return b;
            end
        end
        return 0;
    endfunction

    function automatic alloc_pkg::ivc_req_t random_request();
        alloc_pkg::ivc_req_t r;
        r = '0;
        r.sw_req = 1'($urandom % 2);
        r.ovc_assigned = 1'($urandom % 2);
        r.ovc_not_full = 1'($urandom % 2);
        r.dest = alloc_pkg::dest_sel_t'(1 << ($urandom % `ALLOC_P_1));  // one-hot
        r.ovc_mask = alloc_pkg::vc_mask_t'($urandom % (1 << `ALLOC_V));
        return r;
    endfunction

    task automatic load_golden();
        int fd;
        int code;
        string line;
        logic [REQ_W-1:0] rq [`ALLOC_PV];
        logic [GNT_W-1:0] sg [`ALLOC_P];
        logic [`ALLOC_PV*`ALLOC_V-1:0] og;
        logic [`ALLOC_PV-1:0] ot;
        logic [`ALLOC_P-1:0] pg;
        golden_row_t row;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open the golden file %s", GOLDEN_FILE);
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code <= 1 || line.getc(0) == "/") begin
                continue;  // blank or comment
            end
            code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           rq[0], rq[1], rq[2], rq[3], rq[4], rq[5], rq[6], rq[7],
                           rq[8], rq[9], og, ot, sg[0], sg[1], sg[2], sg[3], sg[4], pg);
            if (code != 18) begin
                other_errors++;
                $display("golden file line has %0d fields instead of 18: %s", code, line);
                continue;
            end
            for (int v = 0; v < `ALLOC_PV; v++) begin
                row.req[v*REQ_W +: REQ_W] = rq[v];
            end
            for (int p = 0; p < `ALLOC_P; p++) begin
                row.sw_grant[p*GNT_W +: GNT_W] = sg[p];
            end
            row.ovc_grant = og;
            row.ovc_taken = ot;
            row.port_granted = pg;
            rows.push_back(row);
        end
        $fclose(fd);
        if (rows.size() == 0) begin
            other_errors++;
            $display("golden file holds no stimulus rows");
        end
    endtask

    task automatic compare_row(int row_no, golden_row_t row);
        alloc_pkg::vc_mask_t exp_vc;
        alloc_pkg::port_grant_t exp_sw;
        for (int v = 0; v < `ALLOC_PV; v++) begin
            exp_vc = row.ovc_grant[v*`ALLOC_V +: `ALLOC_V];
            assert (ovc_grant[v] === exp_vc) else begin
                mismatch_errors++;
                $display("Mismatch at %0t: row %0d ovc_grant[%0d] is %h, expected %h",
                         $time, row_no, v, ovc_grant[v], exp_vc);
            end
        end
        assert (ovc_taken === row.ovc_taken) else begin
            mismatch_errors++;
            $display("Mismatch at %0t: row %0d ovc_taken is %h, expected %h",
                     $time, row_no, ovc_taken, row.ovc_taken);
        end
        for (int p = 0; p < `ALLOC_P; p++) begin
            exp_sw = row.sw_grant[p*GNT_W +: GNT_W];
            assert (sw_grant[p] === exp_sw) else begin
                mismatch_errors++;
                $display("Mismatch at %0t: row %0d sw_grant[%0d] is %h, expected %h",
                         $time, row_no, p, sw_grant[p], exp_sw);
            end
        end
        assert (port_granted === row.port_granted) else begin
            mismatch_errors++;
            $display("Mismatch at %0t: row %0d port_granted is %h, expected %h",
                     $time, row_no, port_granted, row.port_granted);
        end
    endtask

    task automatic report_invariant(string what, int idx);
        invariant_errors++;
        $display("invariant broken at %0t: %s (index %0d)", $time, what, idx);
    endtask

    task automatic check_invariants();
        int out_use [`ALLOC_P];
        int ovc_use [`ALLOC_PV];
        int vc_idx;
        int op;
        for (int p = 0; p < `ALLOC_P; p++) begin
            out_use[p] = 0;
        end
        for (int o = 0; o < `ALLOC_PV; o++) begin
            ovc_use[o] = 0;
        end
        for (int p = 0; p < `ALLOC_P; p++) begin
            assert (port_granted[p] === |sw_grant[p].ivc)
                else report_invariant("port_granted differs from OR of ivc", p);
            if (sw_grant[p].ivc == '0) begin
                assert (sw_grant[p].dest == '0 && !sw_grant[p].spec)
                    else report_invariant("dest or spec set without a granted vc", p);
            end else begin
                vc_idx = p * `ALLOC_V + lowest_bit(sw_grant[p].ivc);
                assert ($onehot(sw_grant[p].ivc) && req[vc_idx].sw_req &&
                        sw_grant[p].dest == req[vc_idx].dest)
                    else report_invariant("switch grant without a matching request", p);
                if (sw_grant[p].spec) begin
                    assert (!req[vc_idx].ovc_assigned && ovc_grant[vc_idx] != '0)
                        else report_invariant("spec grant for a vc without a new output vc", p);
                end else begin
                    assert (req[vc_idx].ovc_assigned && req[vc_idx].ovc_not_full)
                        else report_invariant("non-spec grant for a blocked vc", p);
                end
                for (int k = 0; k < `ALLOC_P_1; k++) begin
                    if (sw_grant[p].dest[k]) begin
                        out_use[other_port(p, k)]++;
                    end
                end
            end
        end
        for (int p = 0; p < `ALLOC_P; p++) begin
            assert (out_use[p] <= 1) else report_invariant("output port granted twice", p);
        end
        for (int v = 0; v < `ALLOC_PV; v++) begin
            if (ovc_grant[v] != '0) begin
                assert ($onehot(ovc_grant[v]) && !req[v].ovc_assigned &&
                        (ovc_grant[v] & ~req[v].ovc_mask) == '0 && $onehot(req[v].dest))
                    else report_invariant("output vc granted without a matching request", v);
                op = other_port(v / `ALLOC_V, lowest_bit(req[v].dest));
                ovc_use[op*`ALLOC_V + lowest_bit(ovc_grant[v])]++;
            end
        end
        for (int o = 0; o < `ALLOC_PV; o++) begin
            assert (ovc_use[o] <= 1) else report_invariant("output vc granted twice", o);
            assert (ovc_taken[o] === (ovc_use[o] != 0))
                else report_invariant("ovc_taken disagrees with ovc_grant", o);
        end
    endtask

    task automatic run_directed();
        for (int n = 0; n < rows.size(); n++) begin
            @(negedge clk);
            for (int v = 0; v < `ALLOC_PV; v++) begin
                req[v] = rows[n].req[v*REQ_W +: REQ_W];
            end
            #3;  // just ahead of the rising edge
            compare_row(n + 1, rows[n]);
            check_invariants();
        end
    endtask

    task automatic run_random();
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            @(negedge clk);
            for (int v = 0; v < `ALLOC_PV; v++) begin
                req[v] = random_request();
            end
            #3;
            check_invariants();
        end
    endtask

    task automatic finish_run();
        $display("error counts: mismatch %0d, invariant %0d, other %0d",
                 mismatch_errors, invariant_errors, other_errors);
        if (mismatch_errors + invariant_errors + other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    initial begin
        seed_value = $urandom(RAND_SEED);
        rst_n = 1'b0;
        for (int v = 0; v < `ALLOC_PV; v++) begin
            req[v] = '0;
        end
        load_golden();
        cycle_limit = rows.size() + RANDOM_CYCLES + TIMEOUT_MARGIN;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        if (rows.size() > 0) begin
            run_directed();
        end
        run_random();
        finish_run();
    end

endmodule

// ==== src/alloc_config.svh ====
`ifndef ALLOC_CONFIG_SVH
`define ALLOC_CONFIG_SVH

// virtual channels per port
`define ALLOC_V 2

// router ports
`define ALLOC_P 5

// a port never routes back to itself
`define ALLOC_P_1 (`ALLOC_P - 1)

`define ALLOC_PV (`ALLOC_V * `ALLOC_P)  // input vcs, port-major

`endif

// ==== src/alloc_pkg.sv ====
`include "alloc_config.svh"

package alloc_pkg;

    typedef logic [`ALLOC_V-1:0]   vc_mask_t;    // one bit per vc of a port
    typedef logic [`ALLOC_P-1:0]   port_mask_t;  // one bit per port

    // bit k of input i selects output k below i, output k+1 otherwise
    typedef logic [`ALLOC_P_1-1:0] dest_sel_t;

    // per input vc request, 10 bits
    typedef struct packed {
        logic      sw_req;        // flit waiting for the crossbar
        logic      ovc_assigned;  // output vc already held
        logic      ovc_not_full;  // held output vc has a free slot
        dest_sel_t dest;
        vc_mask_t  ovc_mask;      // free output vcs at dest
        logic      spare_unused;  // pad bit, driven zero
    } ivc_req_t;

    // per input port switch grant
    typedef struct packed {
        vc_mask_t  ivc;
        dest_sel_t dest;
        logic      spec;  // came from the speculative stage
    } port_grant_t;

endpackage

// ==== src/router_allocator.sv ====
`timescale 1ns/10ps
`include "alloc_config.svh"

module router_allocator (
    input  logic                   clk,
    input  logic                   rst_n,
    input  alloc_pkg::ivc_req_t    req       [`ALLOC_PV],
    output alloc_pkg::vc_mask_t    ovc_grant [`ALLOC_PV],
    output logic [`ALLOC_PV-1:0]   ovc_taken,
    output alloc_pkg::port_grant_t sw_grant  [`ALLOC_P],
    output alloc_pkg::port_mask_t  port_granted
);

    logic [`ALLOC_PV-1:0]  vc_won;                 // input vc got an output vc
    alloc_pkg::vc_mask_t   spec_pick [`ALLOC_P];
    alloc_pkg::port_mask_t valid_spec;

    vc_allocator vc_allocator_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .ovc_grant(ovc_grant),
        .ovc_taken(ovc_taken),
        .vc_won   (vc_won)
    );

    spec_sw_allocator spec_sw_allocator_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .valid_spec  (valid_spec),
        .spec_pick   (spec_pick),
        .sw_grant    (sw_grant),
        .port_granted(port_granted)
    );

    // speculation holds only if the picked vc won vc allocation too
    always_comb begin
        for (int p = 0; p < `ALLOC_P; p++) begin
            valid_spec[p] = |(spec_pick[p] & vc_won[p*`ALLOC_V +: `ALLOC_V]);
        end
    end

endmodule

// ==== src/rr_arbiter.sv ====
`timescale 1ns/10ps

module rr_arbiter #(
    parameter int WIDTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] request,
    input  logic             update,
    output logic [WIDTH-1:0] grant,
    output logic             any_grant
);

    localparam int IDX_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    logic [IDX_W-1:0] ptr;      // slot with highest priority
    logic [IDX_W-1:0] win_idx;

    // first requester at or after ptr, wrapping around
    always_comb begin
        int unsigned slot;
        grant = '0;
        any_grant = 1'b0;
        win_idx = '0;
        for (int k = 0; k < WIDTH; k++) begin
            slot = (int'(ptr) + k) % WIDTH;
            if (!any_grant && request[slot]) begin
                any_grant = 1'b1;
                win_idx = slot[IDX_W-1:0];
            end
        end
        if (any_grant) begin
            grant[win_idx] = 1'b1;
        end
    end

    // pointer moves just past the winner
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (update && any_grant) begin
            if (win_idx == IDX_W'(WIDTH - 1)) begin
                ptr <= '0;  // wrap
            end else begin
                ptr <= win_idx + 1'b1;
            end
        end
    end

    a_grant_legal : assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant) && ((grant & ~request) == '0) && (any_grant == (|request)));

endmodule

// ==== src/spec_sw_allocator.sv ====
`timescale 1ns/10ps
`include "alloc_config.svh"

module spec_sw_allocator (
    input  logic                   clk,
    input  logic                   rst_n,
    input  alloc_pkg::ivc_req_t    req        [`ALLOC_PV],
    input  alloc_pkg::port_mask_t  valid_spec,
    output alloc_pkg::vc_mask_t    spec_pick  [`ALLOC_P],
    output alloc_pkg::port_grant_t sw_grant   [`ALLOC_P],
    output alloc_pkg::port_mask_t  port_granted
);

    alloc_pkg::vc_mask_t    ns_req   [`ALLOC_P];
    alloc_pkg::vc_mask_t    sp_req   [`ALLOC_P];
    alloc_pkg::dest_sel_t   req_dest [`ALLOC_PV];
    alloc_pkg::port_grant_t ns_grant [`ALLOC_P];
    alloc_pkg::port_grant_t sp_grant [`ALLOC_P];
    alloc_pkg::port_mask_t  ns_in_granted;
    alloc_pkg::port_mask_t  ns_out_granted;
    alloc_pkg::port_mask_t  sp_keep;
    alloc_pkg::port_mask_t  out_hits [`ALLOC_P];  // inputs holding each output

    // full output vc only blocks the non-speculative side
    always_comb begin
        int i;
        for (int p = 0; p < `ALLOC_P; p++) begin
            for (int v = 0; v < `ALLOC_V; v++) begin
                i = p * `ALLOC_V + v;
                ns_req[p][v] = req[i].sw_req & req[i].ovc_assigned & req[i].ovc_not_full;
                sp_req[p][v] = req[i].sw_req & ~req[i].ovc_assigned;
                req_dest[i] = req[i].dest;
            end
        end
    end

    sw_alloc_stage ns_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .vc_req     (ns_req),
        .dest       (req_dest),
        .in_pick    (),
        .grant      (ns_grant),
        .in_granted (ns_in_granted),
        .out_granted(ns_out_granted)
    );

    sw_alloc_stage sp_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .vc_req     (sp_req),
        .dest       (req_dest),
        .in_pick    (spec_pick),
        .grant      (sp_grant),
        .in_granted (),
        .out_granted()
    );

    // non-spec grants always win, spec fills the gaps
    always_comb begin
        int op;
        alloc_pkg::dest_sel_t ns_out_rel;
        for (int ip = 0; ip < `ALLOC_P; ip++) begin
            for (int k = 0; k < `ALLOC_P_1; k++) begin
                op = (k < ip) ? k : k + 1;
                ns_out_rel[k] = ns_out_granted[op];
            end
            sp_keep[ip] = valid_spec[ip] && !ns_in_granted[ip] &&
                          (|(sp_grant[ip].dest & ~ns_out_rel));
            if (ns_in_granted[ip]) begin
                sw_grant[ip] = ns_grant[ip];
            end else if (sp_keep[ip]) begin
                sw_grant[ip] = sp_grant[ip];
                sw_grant[ip].spec = 1'b1;
            end else begin
                sw_grant[ip] = '0;
            end
            port_granted[ip] = |sw_grant[ip].ivc;
        end
    end

    // merged grants per absolute output port
    always_comb begin
        int op;
        for (int p = 0; p < `ALLOC_P; p++) begin
            out_hits[p] = '0;
        end
        for (int ip = 0; ip < `ALLOC_P; ip++) begin
            for (int k = 0; k < `ALLOC_P_1; k++) begin
                op = (k < ip) ? k : k + 1;
                out_hits[op][ip] = sw_grant[ip].dest[k];
            end
        end
    end

    for (genvar p = 0; p < `ALLOC_P; p++) begin : g_chk
        a_spec_exclusive : assert property (@(posedge clk) disable iff (!rst_n)
            !(sw_grant[p].spec && (ns_grant[p].ivc != '0)));

        a_out_once : assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(out_hits[p]));
    end

endmodule

// ==== src/sw_alloc_stage.sv ====
`timescale 1ns/10ps
`include "alloc_config.svh"

module sw_alloc_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  alloc_pkg::vc_mask_t    vc_req  [`ALLOC_P],
    input  alloc_pkg::dest_sel_t   dest    [`ALLOC_PV],
    output alloc_pkg::vc_mask_t    in_pick [`ALLOC_P],
    output alloc_pkg::port_grant_t grant   [`ALLOC_P],
    output alloc_pkg::port_mask_t  in_granted,
    output alloc_pkg::port_mask_t  out_granted
);

    alloc_pkg::dest_sel_t pick_dest [`ALLOC_P];  // dest of the picked vc
    alloc_pkg::dest_sel_t out_req   [`ALLOC_P];  // per output, by input rank
    alloc_pkg::dest_sel_t out_grant [`ALLOC_P];
    alloc_pkg::dest_sel_t won_dest  [`ALLOC_P];  // per input, output it won

    for (genvar p = 0; p < `ALLOC_P; p++) begin : g_port
        rr_arbiter #(
            .WIDTH(`ALLOC_V)
        ) in_arb (
            .clk      (clk),
            .rst_n    (rst_n),
            .request  (vc_req[p]),
            .update   (in_granted[p]),
            .grant    (in_pick[p]),
            .any_grant()
        );

        rr_arbiter #(
            .WIDTH(`ALLOC_P_1)
        ) out_arb (
            .clk      (clk),
            .rst_n    (rst_n),
            .request  (out_req[p]),
            .update   (1'b1),
            .grant    (out_grant[p]),
            .any_grant(out_granted[p])
        );
    end

    // input first, then route picks to output arbiters
    always_comb begin
        int rank;
        int k;
        for (int p = 0; p < `ALLOC_P; p++) begin
            pick_dest[p] = '0;
            for (int v = 0; v < `ALLOC_V; v++) begin
                if (in_pick[p][v]) begin
                    pick_dest[p] = pick_dest[p] | dest[p*`ALLOC_V+v];
                end
            end
        end
        for (int op = 0; op < `ALLOC_P; op++) begin
            out_req[op] = '0;
            for (int ip = 0; ip < `ALLOC_P; ip++) begin
                if (ip != op) begin
                    rank = (ip < op) ? ip : ip - 1;
                    k = (op < ip) ? op : op - 1;
                    out_req[op][rank] = pick_dest[ip][k];
                end
            end
        end
    end

    // output wins back into input-relative dest bits
    always_comb begin
        int rank;
        int k;
        for (int ip = 0; ip < `ALLOC_P; ip++) begin
            won_dest[ip] = '0;
        end
        for (int op = 0; op < `ALLOC_P; op++) begin
            for (int ip = 0; ip < `ALLOC_P; ip++) begin
                if (ip != op) begin
                    rank = (ip < op) ? ip : ip - 1;
                    k = (op < ip) ? op : op - 1;
                    won_dest[ip][k] = out_grant[op][rank];
                end
            end
        end
        for (int ip = 0; ip < `ALLOC_P; ip++) begin
            in_granted[ip] = |won_dest[ip];
            grant[ip].ivc = in_granted[ip] ? in_pick[ip] : '0;
            grant[ip].dest = won_dest[ip];
            grant[ip].spec = 1'b0;  // set by the merge above
        end
    end

endmodule

// ==== src/vc_allocator.sv ====
`timescale 1ns/10ps
`include "alloc_config.svh"

module vc_allocator (
    input  logic                 clk,
    input  logic                 rst_n,
    input  alloc_pkg::ivc_req_t  req       [`ALLOC_PV],
    output alloc_pkg::vc_mask_t  ovc_grant [`ALLOC_PV],
    output logic [`ALLOC_PV-1:0] ovc_taken,
    output logic [`ALLOC_PV-1:0] vc_won
);

    // second stage sees every vc of the other ports
    localparam int SEC_W = `ALLOC_V * `ALLOC_P_1;

    alloc_pkg::vc_mask_t first_req   [`ALLOC_PV];
    alloc_pkg::vc_mask_t first_grant [`ALLOC_PV];
    logic [SEC_W-1:0]    sec_req     [`ALLOC_PV];  // indexed by output vc
    logic [SEC_W-1:0]    sec_grant   [`ALLOC_PV];
    int unsigned         grant_cnt;

    // only vcs still waiting for an output vc take part
    always_comb begin
        for (int i = 0; i < `ALLOC_PV; i++) begin
            first_req[i] = req[i].ovc_assigned ? '0 : req[i].ovc_mask;
        end
    end

    for (genvar i = 0; i < `ALLOC_PV; i++) begin : g_ivc
        rr_arbiter #(
            .WIDTH(`ALLOC_V)
        ) first_arb (
            .clk      (clk),
            .rst_n    (rst_n),
            .request  (first_req[i]),
            .update   (vc_won[i]),  // hold priority until served
            .grant    (first_grant[i]),
            .any_grant()
        );
    end

    for (genvar o = 0; o < `ALLOC_PV; o++) begin : g_ovc
        rr_arbiter #(
            .WIDTH(SEC_W)
        ) second_arb (
            .clk      (clk),
            .rst_n    (rst_n),
            .request  (sec_req[o]),
            .update   (1'b1),
            .grant    (sec_grant[o]),
            .any_grant(ovc_taken[o])
        );
    end

    // steer each first stage pick to its dest port
    always_comb begin
        int op;
        int ov;
        int rank;
        int k;
        int ivc;
        for (int o = 0; o < `ALLOC_PV; o++) begin
            op = o / `ALLOC_V;
            ov = o % `ALLOC_V;
            sec_req[o] = '0;
            for (int ip = 0; ip < `ALLOC_P; ip++) begin
                if (ip != op) begin
                    rank = (ip < op) ? ip : ip - 1;  // own port skipped
                    k = (op < ip) ? op : op - 1;     // dest bit for op
                    for (int iv = 0; iv < `ALLOC_V; iv++) begin
                        ivc = ip * `ALLOC_V + iv;
                        sec_req[o][rank*`ALLOC_V+iv] = req[ivc].dest[k] & first_grant[ivc][ov];
                    end
                end
            end
        end
    end

    // winners back to their input vcs
    always_comb begin
        int op;
        int ov;
        int rank;
        int ivc;
        for (int i = 0; i < `ALLOC_PV; i++) begin
            ovc_grant[i] = '0;
        end
        for (int o = 0; o < `ALLOC_PV; o++) begin
            op = o / `ALLOC_V;
            ov = o % `ALLOC_V;
            for (int ip = 0; ip < `ALLOC_P; ip++) begin
                if (ip != op) begin
                    rank = (ip < op) ? ip : ip - 1;
                    for (int iv = 0; iv < `ALLOC_V; iv++) begin
                        ivc = ip * `ALLOC_V + iv;
                        ovc_grant[ivc][ov] = ovc_grant[ivc][ov] | sec_grant[o][rank*`ALLOC_V+iv];
                    end
                end
            end
        end
        grant_cnt = 0;
        for (int i = 0; i < `ALLOC_PV; i++) begin
            vc_won[i] = |ovc_grant[i];
            grant_cnt += $countones(ovc_grant[i]);
        end
    end

    // every taken output vc lands in exactly one input vc
    a_ovc_unique : assert property (@(posedge clk) disable iff (!rst_n)
        grant_cnt == $countones(ovc_taken));

endmodule
